// File: tests/cam_fb_stim.txt
# byte <hex> | gap <cycles> | fill <words> | write <region 0..4, 4 is status>
# read <bank> <addr hex> <word hex, or m for the shadow word> | status <word hex>
status 00000000
byte 11
byte 22
byte 33
byte 44
read 0 000 11223344
status 00000100
byte aa
byte bb
gap 5
status 00000000
byte cc
byte dd
read 0 001 aabbccdd
fill 510
status 00000101
read 0 1ff m
fill 1
read 1 000 m
fill 1535
status 00000100
read 3 1ff m
byte 01
byte 02
byte 03
byte 04
read 0 000 01020304
write 0
write 4
write 3
read 0 000 01020304
read 3 1ff m

// File: cam_fb.f
hw/cam_fb_bus_pkg.sv
hw/cam_fb_capture_pkg.sv
hw/cam_byte_packer.sv
hw/fb_write_ctrl.sv
hw/fb_ram.sv
hw/wb_slave_ctrl.sv
hw/cam_fb_top.sv
tests/cam_fb_tb.sv

// File: Bender.yml
package:
  name: cam_fb

sources:
  # Packages first, then the RTL from leaf to top
  - files:
      - hw/cam_fb_bus_pkg.sv
      - hw/cam_fb_capture_pkg.sv
      - hw/cam_byte_packer.sv
      - hw/fb_write_ctrl.sv
      - hw/fb_ram.sv
      - hw/wb_slave_ctrl.sv
      - hw/cam_fb_top.sv

  # Testbench, top module cam_fb_tb
  - target: test
    files:
      - tests/cam_fb_tb.sv

// File: tests/cam_fb_tb.sv
/*
 * Testbench for the camera frame-buffer peripheral.
 * Reads command lines from the stimulus file, drives camera bytes and
 * host bus cycles, and checks read data and status against the file
 * or against a shadow memory that follows the packing and counter rules.
 */
`timescale 1ns/1ns

module cam_fb_tb;

	localparam int FB_WORDS = 2048;  // Four banks of 512 words

	logic        clk;
	logic        rst;
	logic [10:0] adr;
	logic [4:0]  cyc;  // Banks 0..3, status on bit 4
	logic        stb;
	logic        we;
	logic [31:0] dat;
	logic [3:0]  byte_stb;
	logic        vsync;
	logic        href;
	logic [7:0]  cam_dat;
	logic [31:0] ram_dat [4];
	logic [31:0] bank_snap [4];      // All bank outputs seen during the ack
	logic [31:0] status_dat;
	logic        ack;

	logic [31:0] shadow [FB_WORDS];  // Expected bank contents
	logic [31:0] model_acc;          // Bytes of the word in progress
	int          model_fill;         // Bytes held by the model
	int          model_cnt;          // Model write counter
	logic [31:0] lfsr_q = 32'h4ca2;
	int          cycle_cnt;
	int          limit_cycles;

	cam_fb_top i_cam_fb_top (
		.WBs_CLK_i        (clk),
		.WBs_RST_i        (rst),
		.WBs_ADR_i        (adr),
		.WBs_RAM0_CYC_i   (cyc[0]),
		.WBs_RAM1_CYC_i   (cyc[1]),
		.WBs_RAM2_CYC_i   (cyc[2]),
		.WBs_RAM3_CYC_i   (cyc[3]),
		.WBs_STATUS_CYC_i (cyc[4]),
		.WBs_STB_i        (stb),
		.WBs_WE_i         (we),
		.WBs_DAT_i        (dat),
		.WBs_BYTE_STB_i   (byte_stb),
		.WBs_RAM0_DAT_o   (ram_dat[0]),
		.WBs_RAM1_DAT_o   (ram_dat[1]),
		.WBs_RAM2_DAT_o   (ram_dat[2]),
		.WBs_RAM3_DAT_o   (ram_dat[3]),
		.WBs_RAM_STATUS_o (status_dat),
		.WBs_ACK_o        (ack),
		.vsync_i          (vsync),
		.href_i           (href),
		.cam_dat_i        (cam_dat)
	);

	always #4 clk = ~clk;  // 8 ns period

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			abort_run($sformatf("** Error @ %0t ns: %s, got %h expected %h",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois taps
	endfunction

	task automatic next_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			b      = {b[6:0], lfsr_q[0]};  // One step per bit taken
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic send_byte(input logic [7:0] v);
		@(posedge clk);
		vsync   <= 1'b1;
		href    <= 1'b1;
		cam_dat <= v;
		model_acc = {model_acc[23:0], v};  // First byte ends up on top
		model_fill++;
		if (model_fill == 4) begin
			shadow[model_cnt] = model_acc;
			model_cnt  = (model_cnt + 1) % FB_WORDS;
			model_fill = 0;
		end
	endtask

	task automatic fill_words(input int words);
		logic [7:0] b;
		for (int w = 0; w < words * 4; w++) begin
			next_byte(b);
			send_byte(b);
		end
	endtask

	task automatic drop_href();
		@(posedge clk);
		href <= 1'b0;  // Frame level stays as it was
	endtask

	task automatic run_gap(input int cycles);
		@(posedge clk);
		href  <= 1'b0;
		vsync <= 1'b0;
		repeat (cycles - 1) @(posedge clk);
	endtask

	task automatic bus_cycle(input int region, input logic wr, input logic [10:0] a,
		output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		adr      <= a;
		we       <= wr;
		dat      <= 32'ha5a5_5a5a;  // Any pattern, writes are dropped
		byte_stb <= {4{wr}};
		cyc      <= 5'b1 << region;
		stb      <= 1'b1;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 16) begin
				abort_run("No acknowledge from the DUT within 16 cycles");
			end
		end while (ack !== 1'b1);
		rdata = (region == 4) ? status_dat : ram_dat[region];  // Valid during ack
		for (int b = 0; b < 4; b++) begin
			bank_snap[b] = ram_dat[b];
		end
		@(posedge clk);
		cyc <= '0;
		stb <= 1'b0;
		we  <= 1'b0;
		@(negedge clk);
		check(ack, 1'b0, "acknowledge longer than one cycle");
	endtask

	// Every bank follows the live address, so the other banks must match too
	task automatic check_other_banks(input int bank, input logic [8:0] a);
		logic [31:0] model_word;
		for (int b = 0; b < 4; b++) begin
			model_word = shadow[b * 512 + a];
			if (b != bank && !$isunknown(model_word)) begin
				check(bank_snap[b], model_word,
					$sformatf("bank %0d word %h beside the read", b, a));
			end
		end
	endtask

	// ----------------------------------------
	// Timeout
	// ----------------------------------------
	always @(posedge clk) begin
		cycle_cnt++;
		if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
			abort_run($sformatf("Timeout, run exceeded %0d cycles", limit_cycles));
		end
	end

	// ----------------------------------------
	// Stimulus interpreter
	// ----------------------------------------
	initial begin
		int          fd;
		int          n;
		int          v;
		string       line;
		string       cmd;
		string       t1;
		string       t2;
		string       t3;
		string       cmd_q [$];
		int          arg_q [$];
		logic [31:0] adr_q [$];
		logic [31:0] exp_q [$];
		bit          model_q [$];
		logic [31:0] rd;
		logic [31:0] expected;

		clk = 1'b0;  // All DUT inputs idle, reset held
		rst = 1'b1;
		adr = '0;
		cyc = '0;
		stb = 1'b0;
		we = 1'b0;
		dat = '0;
		byte_stb = '0;
		vsync = 1'b0;
		href = 1'b0;
		cam_dat = '0;
		model_acc = '0;
		model_fill = 0;
		model_cnt = 0;
		cycle_cnt = 0;
		limit_cycles = 0;

		fd = $fopen("tests/cam_fb_stim.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open the stimulus file tests/cam_fb_stim.txt");
		end
		n = 30;  // Reset and margin
		while ($fgets(line, fd)) begin
			if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
			t1 = "";
			t2 = "";
			t3 = "";
			void'($sscanf(line, "%s %s %s %s", cmd, t1, t2, t3));
			v = 0;
			expected = '0;
			rd = '0;
			if (cmd != "byte" && cmd != "gap" && cmd != "fill" && cmd != "read" &&
				cmd != "status" && cmd != "write") begin
				abort_run($sformatf("Unknown command in stimulus line: %s", line));
			end
			if ((cmd == "byte" || cmd == "status") && $sscanf(t1, "%h", v) != 1) begin
				abort_run($sformatf("Missing hex value in stimulus line: %s", line));
			end
			if ((cmd == "gap" || cmd == "fill" || cmd == "write" || cmd == "read") &&
				$sscanf(t1, "%d", v) != 1) begin
				abort_run($sformatf("Missing number in stimulus line: %s", line));
			end
			if (cmd == "read" && ($sscanf(t2, "%h", rd) != 1 ||
				(t3 != "m" && $sscanf(t3, "%h", expected) != 1))) begin
				abort_run($sformatf("Bad read arguments in stimulus line: %s", line));
			end
			cmd_q.push_back(cmd);
			arg_q.push_back(v);
			adr_q.push_back(rd);
			exp_q.push_back(cmd == "status" ? v : expected);
			model_q.push_back(cmd == "read" && t3 == "m");  // Expect the shadow word
			n += (cmd == "fill") ? 8 * v : 20;
		end
		$fclose(fd);
		limit_cycles = n;

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check(ack, 1'b0, "acknowledge after reset");

		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
			"byte":  send_byte(arg_q[i][7:0]);
			"gap":   run_gap(arg_q[i]);
			"fill":  fill_words(arg_q[i]);
			"write": begin
				drop_href();
				bus_cycle(arg_q[i], 1'b1, 11'h000, rd);  // Ack only, nothing stored
			end
			"status": begin
				drop_href();
				bus_cycle(4, 1'b0, 11'h000, rd);
				check(rd, exp_q[i], "status word");
			end
			default: begin
				drop_href();
				bus_cycle(arg_q[i], 1'b0, adr_q[i][10:0], rd);
				expected = model_q[i] ? shadow[arg_q[i] * 512 + adr_q[i][8:0]] : exp_q[i];
				check(rd, expected, $sformatf("bank %0d word %h", arg_q[i], adr_q[i]));
				check_other_banks(arg_q[i], adr_q[i][8:0]);
			end
			endcase
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: hw/cam_fb_top.sv
/*
 * Camera frame-buffer peripheral, top level.
 * Camera bytes sampled on the bus clock are packed into words and
 * written round-robin into four 512-word banks. The host reads each
 * bank through its own cycle line and reads a status word with the
 * frame level and fill bank. Host writes are acknowledged and dropped.
 */
`timescale 1ns/1ns

module cam_fb_top (
	// Bus clock and reset, also used for camera sampling
	input  logic                                     WBs_CLK_i,
	input  logic                                     WBs_RST_i,
	// Host bus
	input  logic [cam_fb_bus_pkg::ADR_W-1:0]         WBs_ADR_i,         // Bits 8:0 pick the word
	input  logic                                     WBs_RAM0_CYC_i,
	input  logic                                     WBs_RAM1_CYC_i,
	input  logic                                     WBs_RAM2_CYC_i,
	input  logic                                     WBs_RAM3_CYC_i,
	input  logic                                     WBs_STATUS_CYC_i,
	input  logic                                     WBs_STB_i,
	input  logic                                     WBs_WE_i,          // Writes only get an ack
	input  logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_DAT_i,         // No writable storage
	input  logic [cam_fb_bus_pkg::DATA_W/8-1:0]      WBs_BYTE_STB_i,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_RAM0_DAT_o,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_RAM1_DAT_o,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_RAM2_DAT_o,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_RAM3_DAT_o,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]        WBs_RAM_STATUS_o,
	output logic                                     WBs_ACK_o,
	// Camera
	input  logic                                     vsync_i,           // Frame level
	input  logic                                     href_i,            // Line level
	input  logic [cam_fb_capture_pkg::PIX_W-1:0]     cam_dat_i
);

	logic                                       pix_valid;    // Byte qualifier
	logic [cam_fb_capture_pkg::WORD_W-1:0]      packed_word;
	logic                                       word_valid;
	logic [cam_fb_capture_pkg::BANK_ADR_W-1:0]  wr_addr;
	logic [cam_fb_capture_pkg::NUM_BANKS-1:0]   bank_we;
	logic [cam_fb_capture_pkg::BANK_SEL_W-1:0]  cur_bank;
	logic [cam_fb_bus_pkg::NUM_REGIONS-1:0]     cyc_vec;
	logic [cam_fb_capture_pkg::NUM_BANKS-1:0][cam_fb_capture_pkg::WORD_W-1:0] bank_rd_data;

	// ----------------------------------------
	// Capture path
	// ----------------------------------------
	assign pix_valid = href_i & vsync_i;  // Only inside an active line

	cam_byte_packer i_cam_byte_packer (
		.clk_i        (WBs_CLK_i),
		.rst_i        (WBs_RST_i),
		.pix_valid_i  (pix_valid),
		.pix_i        (cam_dat_i),
		.word_o       (packed_word),
		.word_valid_o (word_valid)
	);

	fb_write_ctrl i_fb_write_ctrl (
		.clk_i        (WBs_CLK_i),
		.rst_i        (WBs_RST_i),
		.word_valid_i (word_valid),
		.wr_addr_o    (wr_addr),
		.bank_we_o    (bank_we),
		.cur_bank_o   (cur_bank)
	);

	// ----------------------------------------
	// Banks
	// ----------------------------------------
	for (genvar b = 0; b < cam_fb_capture_pkg::NUM_BANKS; b++) begin : g_bank
		fb_ram i_fb_ram (
			.clk_i     (WBs_CLK_i),
			.we_i      (bank_we[b]),
			.wr_addr_i (wr_addr),
			.rd_addr_i (WBs_ADR_i[cam_fb_capture_pkg::BANK_ADR_W-1:0]),  // Live address
			.wr_data_i (packed_word),
			.rd_data_o (bank_rd_data[b])
		);
	end

	assign WBs_RAM0_DAT_o = bank_rd_data[0];
	assign WBs_RAM1_DAT_o = bank_rd_data[1];
	assign WBs_RAM2_DAT_o = bank_rd_data[2];
	assign WBs_RAM3_DAT_o = bank_rd_data[3];

	// ----------------------------------------
	// Bus control
	// ----------------------------------------
	assign cyc_vec = {WBs_STATUS_CYC_i, WBs_RAM3_CYC_i, WBs_RAM2_CYC_i,
		WBs_RAM1_CYC_i, WBs_RAM0_CYC_i};  // Status is the top region

	wb_slave_ctrl i_wb_slave_ctrl (
		.clk_i      (WBs_CLK_i),
		.rst_i      (WBs_RST_i),
		.cyc_i      (cyc_vec),
		.stb_i      (WBs_STB_i),
		.vsync_i    (vsync_i),
		.cur_bank_i (cur_bank),
		.ack_o      (WBs_ACK_o),
		.status_o   (WBs_RAM_STATUS_o)
	);

endmodule

// File: hw/wb_slave_ctrl.sv
/*
 * Bus slave control for the frame buffer.
 * Generates the acknowledge as a registered one-cycle pulse for any
 * active cycle line together with the strobe, with no wait states.
 * Also builds the combinational status word from the frame level
 * and the bank currently being filled.
 */
`timescale 1ns/1ns

module wb_slave_ctrl (
	input  logic                                       clk_i,
	input  logic                                       rst_i,
	input  logic [cam_fb_bus_pkg::NUM_REGIONS-1:0]     cyc_i,       // Banks 0..3, status on top
	input  logic                                       stb_i,
	input  logic                                       vsync_i,
	input  logic [cam_fb_capture_pkg::BANK_SEL_W-1:0]  cur_bank_i,
	output logic                                       ack_o,
	output logic [cam_fb_bus_pkg::DATA_W-1:0]          status_o
);

	logic ack_nxt;  // Request seen and not yet answered

	// ----------------------------------------
	// Acknowledge
	// ----------------------------------------
	// Low ack in the term forces a gap, so every pulse lasts one cycle
	assign ack_nxt = (|cyc_i) & stb_i & ~ack_o;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= ack_nxt;
		end
	end

	// ----------------------------------------
	// Status word
	// ----------------------------------------
	always_comb begin
		status_o                                 = '0;  // Unused bits read zero
		status_o[cam_fb_bus_pkg::STAT_VSYNC_BIT] = vsync_i;  // Live level
		status_o[cam_fb_bus_pkg::STAT_BANK_LSB +: cam_fb_capture_pkg::BANK_SEL_W] = cur_bank_i;
	end

endmodule

// File: hw/fb_ram.sv
/*
 * One frame-buffer bank of 512 words by 32 bits.
 * Simple dual port: the capture side writes on the clock edge when
 * we_i is high, the bus side gets a registered read of rd_addr_i on
 * every edge. A same-address read and write returns the old word.
 */
`timescale 1ns/1ns

module fb_ram (
	input  logic                                       clk_i,
	input  logic                                       we_i,
	input  logic [cam_fb_capture_pkg::BANK_ADR_W-1:0]  wr_addr_i,
	input  logic [cam_fb_capture_pkg::BANK_ADR_W-1:0]  rd_addr_i,
	input  logic [cam_fb_capture_pkg::WORD_W-1:0]      wr_data_i,
	output logic [cam_fb_capture_pkg::WORD_W-1:0]      rd_data_o
);

	// Contents undefined until the capture side fills them
	logic [cam_fb_capture_pkg::WORD_W-1:0] mem [cam_fb_capture_pkg::BANK_DEPTH];

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[wr_addr_i] <= wr_data_i;  // Camera side
		end
	end

	// ----------------------------------------
	// Read port
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		rd_data_o <= mem[rd_addr_i];  // Follows the live bus address
	end

endmodule

// File: hw/fb_write_ctrl.sv
/*
 * Frame-buffer write controller.
 * Keeps the 11-bit write counter that steps once per packed word and
 * wraps after 2048 words. The top two counter bits pick the bank and
 * the lower nine give the address inside it. Bank write enables are
 * one-hot and only active while the word pulse is high.
 */
`timescale 1ns/1ns

module fb_write_ctrl (
	input  logic                                       clk_i,
	input  logic                                       rst_i,
	input  logic                                       word_valid_i,  // From the packer
	output logic [cam_fb_capture_pkg::BANK_ADR_W-1:0]  wr_addr_o,
	output logic [cam_fb_capture_pkg::NUM_BANKS-1:0]   bank_we_o,
	output logic [cam_fb_capture_pkg::BANK_SEL_W-1:0]  cur_bank_o     // Bank being filled
);

	logic [cam_fb_capture_pkg::FB_CNT_W-1:0] fb_cnt_q;  // Next word slot

	// ----------------------------------------
	// Write counter
	// ----------------------------------------
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			fb_cnt_q <= '0;
		end else if (word_valid_i) begin
			fb_cnt_q <= fb_cnt_q + 1'b1;  // Rolls 2047 -> 0 by width
		end
	end

	// Split the counter into bank and in-bank address
	assign wr_addr_o  = fb_cnt_q[cam_fb_capture_pkg::BANK_ADR_W-1:0];
	assign cur_bank_o = fb_cnt_q[cam_fb_capture_pkg::FB_CNT_W-1 -: cam_fb_capture_pkg::BANK_SEL_W];

	// One-hot decode, gated by the word pulse
	always_comb begin
		bank_we_o             = '0;
		bank_we_o[cur_bank_o] = word_valid_i;
	end

endmodule

// File: hw/cam_byte_packer.sv
/*
 * Camera byte packer.
 * Collects qualified camera bytes into 32-bit words, first byte in
 * the most significant position. The completed word is registered on
 * the edge that takes the fourth byte and word_valid_o is high for
 * the following cycle. Progress holds while pix_valid_i is low.
 */
`timescale 1ns/1ns

module cam_byte_packer (
	input  logic                                   clk_i,
	input  logic                                   rst_i,
	input  logic                                   pix_valid_i,   // HREF and VSYNC both high
	input  logic [cam_fb_capture_pkg::PIX_W-1:0]   pix_i,
	output logic [cam_fb_capture_pkg::WORD_W-1:0]  word_o,
	output logic                                   word_valid_o   // One-cycle pulse
);

	cam_fb_capture_pkg::pack_state_t state_q;  // Bytes held so far

	// Holds up to three bytes, oldest in the top slot
	logic [(cam_fb_capture_pkg::BYTES_PER_WORD-1)*cam_fb_capture_pkg::PIX_W-1:0] hold_q;

	// ----------------------------------------
	// Packing FSM
	// ----------------------------------------
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_q      <= cam_fb_capture_pkg::PACK_EMPTY;
			hold_q       <= '0;
			word_o       <= '0;
			word_valid_o <= 1'b0;
		end else begin
			word_valid_o <= 1'b0;  // Default, pulse only on completion
			if (pix_valid_i) begin
				case (state_q)
				cam_fb_capture_pkg::PACK_EMPTY: begin
					hold_q  <= {hold_q[15:0], pix_i};  // Stale bytes shift out later
					state_q <= cam_fb_capture_pkg::PACK_ONE;
				end
				cam_fb_capture_pkg::PACK_ONE: begin
					hold_q  <= {hold_q[15:0], pix_i};
					state_q <= cam_fb_capture_pkg::PACK_TWO;
				end
				cam_fb_capture_pkg::PACK_TWO: begin
					hold_q  <= {hold_q[15:0], pix_i};
					state_q <= cam_fb_capture_pkg::PACK_THREE;
				end
				default: begin
					// Fourth byte goes straight into the output word
					word_o       <= {hold_q, pix_i};
					word_valid_o <= 1'b1;
					state_q      <= cam_fb_capture_pkg::PACK_EMPTY;
				end
				endcase
			end
			// No valid byte: state and held bytes stay put across the gap
		end
	end

endmodule

// File: hw/cam_fb_capture_pkg.sv
/*
 * Camera capture constants for the frame-buffer peripheral.
 * Describes the camera byte, the packed word, the bank organisation
 * and the write counter, plus the state type of the byte packer.
 * The counter splits as bank select on top and bank address below.
 */

package cam_fb_capture_pkg;

	// ----------------------------------------
	// Pixel stream and packed words
	// ----------------------------------------
	localparam int PIX_W          = 8;   // One camera byte
	localparam int WORD_W         = 32;  // Word stored in a bank
	localparam int BYTES_PER_WORD = 4;   // First byte lands in the MSBs

	// ----------------------------------------
	// Frame-buffer organisation
	// ----------------------------------------
	localparam int NUM_BANKS  = 4;
	localparam int BANK_DEPTH = 512;  // Words per bank
	localparam int BANK_ADR_W = 9;    // log2 of BANK_DEPTH
	localparam int BANK_SEL_W = 2;    // log2 of NUM_BANKS
	localparam int FB_CNT_W   = 11;   // Bank select plus bank address

	// Packer progress within the current word
	typedef enum logic [1:0] {
		PACK_EMPTY = 2'd0,  // Nothing held
		PACK_ONE   = 2'd1,  // One byte held
		PACK_TWO   = 2'd2,  // Two bytes held
		PACK_THREE = 2'd3   // Next byte completes the word
	} pack_state_t;

endpackage

// File: hw/cam_fb_bus_pkg.sv
/*
 * Host bus constants for the camera frame-buffer peripheral.
 * Covers the slave data and address widths, the number of cycle
 * lines decoded by the host bridge and the bit layout of the status
 * word. Modules refer to these by package-scoped names.
 */

package cam_fb_bus_pkg;

	// ----------------------------------------
	// Bus geometry
	// ----------------------------------------
	localparam int DATA_W      = 32;  // Read and write data width
	localparam int ADR_W       = 11;  // Word address from the bridge
	localparam int NUM_REGIONS = 5;   // Four banks plus status

	// ----------------------------------------
	// Status word layout
	// ----------------------------------------
	// Bits not listed here always read as zero
	localparam int STAT_VSYNC_BIT = 8;  // Live frame level
	localparam int STAT_BANK_LSB  = 0;  // Bank being filled, two bits wide

endpackage
